/* bias_cfg.svh */
`ifndef BIAS_CFG_SVH
`define BIAS_CFG_SVH

////////////////////////////////
// Lane layout
////////////////////////////////

`define BIAS_X_PE     4                        // Bias lanes per DDR word
`define BIAS_W        16                       // Stored bias width
`define BIAS_OUT_W    20                       // Scaled lane width
`define BIAS_DDR_W    (`BIAS_X_PE * `BIAS_W)   // One FIFO word, one buffer entry

////////////////////////////////
// Buffer and control sizes
////////////////////////////////

`define BIAS_ADDR_W   7
`define BIAS_DEPTH    (1 << `BIAS_ADDR_W)      // 128 entries
`define BIAS_SHIFT_W  5
`define BIAS_CNT_W    8                        // Words per fill

`endif

/* bias_pkg.sv */
`default_nettype none

`include "bias_cfg.svh"

package bias_pkg;

	// Lane k sits in slice k from the bottom
	typedef logic [`BIAS_DDR_W-1:0] ddr_word_t;
	typedef logic signed [`BIAS_W-1:0] bias_t;
	typedef logic signed [`BIAS_OUT_W-1:0] bias_out_t;
	typedef logic [`BIAS_X_PE*`BIAS_OUT_W-1:0] bias_vec_t; // Same lane order as ddr_word_t

	typedef logic [`BIAS_ADDR_W-1:0] bb_addr_t;
	typedef logic [`BIAS_SHIFT_W-1:0] shift_t;
	typedef logic [`BIAS_CNT_W-1:0] word_cnt_t;

	typedef enum logic [1:0] {
		FETCH_IDLE,
		FETCH_PULL,   // Wait for a word in the DDR FIFO
		FETCH_WRITE,  // FIFO data valid, write it
		FETCH_DONE    // cfg_ack high
	} fetch_state_t;

	typedef enum logic [1:0] {
		READ_IDLE,
		READ_READ,    // Buffer samples the address
		READ_HOLD,    // Buffer data valid, scale it
		READ_DONE     // rd_ack high
	} reader_state_t;

endpackage

`default_nettype wire

/* bias_fetch.sv */
`timescale 1ns/100ps
`default_nettype none

module bias_fetch (
	input  logic                 clk,
	input  logic                 rst,

	// Fill request
	input  logic                 cfg_req,
	input  bias_pkg::word_cnt_t  cfg_count,
	input  bias_pkg::bb_addr_t   cfg_addr,
	output logic                 cfg_ack,
	output logic                 fetch_busy,

	// DDR read FIFO
	input  logic                 fifo_empty,
	output logic                 fifo_req,
	input  bias_pkg::ddr_word_t  fifo_data,

	// Bias buffer write port
	output logic                 wr_en,
	output bias_pkg::bb_addr_t   wr_addr,
	output bias_pkg::ddr_word_t  wr_data
);

	bias_pkg::fetch_state_t state, state_next;
	bias_pkg::word_cnt_t cnt_q; // Words still to move
	bias_pkg::bb_addr_t addr_q;

	////////////////////////////////
	// FSM
	////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= bias_pkg::FETCH_IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			bias_pkg::FETCH_IDLE: begin
				if (cfg_req) begin
					// Empty fill goes straight to the acknowledge
					if (cfg_count == '0) begin
						state_next = bias_pkg::FETCH_DONE;
					end else begin
						state_next = bias_pkg::FETCH_PULL;
					end
				end
			end
			bias_pkg::FETCH_PULL: begin
				if (!fifo_empty) begin
					state_next = bias_pkg::FETCH_WRITE;
				end
			end
			bias_pkg::FETCH_WRITE: begin
				if (cnt_q == bias_pkg::word_cnt_t'(1)) begin
					state_next = bias_pkg::FETCH_DONE; // Last word
				end else begin
					state_next = bias_pkg::FETCH_PULL;
				end
			end
			bias_pkg::FETCH_DONE: begin
				if (!cfg_req) begin
					state_next = bias_pkg::FETCH_IDLE;
				end
			end
			default: state_next = bias_pkg::FETCH_IDLE;
		endcase
	end

	////////////////////////////////
	// Count and address
	////////////////////////////////

	always_ff @(posedge clk) begin
		if (state == bias_pkg::FETCH_IDLE && cfg_req) begin
			cnt_q  <= cfg_count;
			addr_q <= cfg_addr;
		end else if (state == bias_pkg::FETCH_WRITE) begin
			cnt_q  <= cnt_q - bias_pkg::word_cnt_t'(1);
			addr_q <= addr_q + bias_pkg::bb_addr_t'(1); // Wraps 127 -> 0
		end
	end

	// One request per word, never into an empty FIFO
	assign fifo_req = (state == bias_pkg::FETCH_PULL) && !fifo_empty;

	// Word arrives the cycle after fifo_req
	assign wr_en   = (state == bias_pkg::FETCH_WRITE);
	assign wr_addr = addr_q;
	assign wr_data = fifo_data;

	assign cfg_ack    = (state == bias_pkg::FETCH_DONE);
	assign fetch_busy = (state != bias_pkg::FETCH_IDLE);

endmodule

`default_nettype wire

/* bias_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "bias_cfg.svh"

module bias_buffer (
	input  logic                 clk,

	// Write port, driven by the fetch side
	input  logic                 wr_en,
	input  bias_pkg::bb_addr_t   wr_addr,
	input  bias_pkg::ddr_word_t  wr_data,

	// Read port, one cycle latency
	input  bias_pkg::bb_addr_t   rd_addr,
	output bias_pkg::ddr_word_t  rd_data
);

	////////////////////////////////
	// Storage
	////////////////////////////////

	// One packed word of lanes per entry
	bias_pkg::ddr_word_t mem [`BIAS_DEPTH];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	////////////////////////////////
	// Registered read
	////////////////////////////////

	// Old data on a same-cycle write to rd_addr
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

/* bias_reader.sv */
`timescale 1ns/100ps
`default_nettype none

`include "bias_cfg.svh"

module bias_reader (
	input  logic                 clk,
	input  logic                 rst,

	// Read request
	input  logic                 rd_req,
	input  bias_pkg::bb_addr_t   rd_addr_in,
	input  bias_pkg::shift_t     rd_shift,
	input  logic                 fetch_busy, // Fill in progress, hold off
	output logic                 rd_ack,
	output bias_pkg::bias_vec_t  bias_out,

	// Bias buffer read port
	output bias_pkg::bb_addr_t   buf_addr,
	input  bias_pkg::ddr_word_t  buf_data
);

	bias_pkg::reader_state_t state, state_next;
	bias_pkg::bb_addr_t addr_q;
	bias_pkg::shift_t shift_q;
	bias_pkg::bias_vec_t scaled;
	bias_pkg::bias_vec_t bias_q;

	logic accept;

	assign accept = (state == bias_pkg::READ_IDLE) && rd_req && !fetch_busy;

	////////////////////////////////
	// FSM
	////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= bias_pkg::READ_IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			bias_pkg::READ_IDLE: if (accept) state_next = bias_pkg::READ_READ;
			bias_pkg::READ_READ: state_next = bias_pkg::READ_HOLD;
			bias_pkg::READ_HOLD: state_next = bias_pkg::READ_DONE;
			bias_pkg::READ_DONE: if (!rd_req) state_next = bias_pkg::READ_IDLE;
			default:             state_next = bias_pkg::READ_IDLE;
		endcase
	end

	// Sign extend each lane, shift left, keep the low bits
	always_comb begin
		bias_pkg::bias_t lane;
		bias_pkg::bias_out_t ext;
		scaled = '0;
		for (int k = 0; k < `BIAS_X_PE; k++) begin
			lane = buf_data[k*`BIAS_W +: `BIAS_W];
			ext  = bias_pkg::bias_out_t'(lane);
			scaled[k*`BIAS_OUT_W +: `BIAS_OUT_W] = ext << shift_q;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			addr_q  <= rd_addr_in;
			shift_q <= rd_shift;
		end
		if (state == bias_pkg::READ_HOLD) begin
			bias_q <= scaled; // Stable through READ_DONE
		end
	end

	assign buf_addr = addr_q;
	assign rd_ack   = (state == bias_pkg::READ_DONE);
	assign bias_out = bias_q;

endmodule

`default_nettype wire

/* bias_path_top.sv */
`timescale 1ns/100ps
`default_nettype none

module bias_path_top (
	input  logic                 clk,
	input  logic                 rst,

	// Fill request
	input  logic                 cfg_req,
	input  bias_pkg::word_cnt_t  cfg_count,
	input  bias_pkg::bb_addr_t   cfg_addr,
	output logic                 cfg_ack,

	// DDR read FIFO
	input  logic                 fifo_empty,
	output logic                 fifo_req,
	input  bias_pkg::ddr_word_t  fifo_data,

	// Bias read request from the PE side
	input  logic                 rd_req,
	input  bias_pkg::bb_addr_t   rd_addr,
	input  bias_pkg::shift_t     rd_shift,
	output logic                 rd_ack,
	output bias_pkg::bias_vec_t  bias_out
);

	logic fetch_busy;
	logic wr_en;
	bias_pkg::bb_addr_t wr_addr;
	bias_pkg::ddr_word_t wr_data;
	bias_pkg::bb_addr_t buf_addr;
	bias_pkg::ddr_word_t buf_data;

	bias_fetch fetch0 (
		.clk        (clk),
		.rst        (rst),
		.cfg_req    (cfg_req),
		.cfg_count  (cfg_count),
		.cfg_addr   (cfg_addr),
		.cfg_ack    (cfg_ack),
		.fetch_busy (fetch_busy),
		.fifo_empty (fifo_empty),
		.fifo_req   (fifo_req),
		.fifo_data  (fifo_data),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data)
	);

	bias_buffer buffer0 (
		.clk     (clk),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_addr (buf_addr),
		.rd_data (buf_data)
	);

	// Reads wait out any fill in progress
	bias_reader reader0 (
		.clk        (clk),
		.rst        (rst),
		.rd_req     (rd_req),
		.rd_addr_in (rd_addr),
		.rd_shift   (rd_shift),
		.fetch_busy (fetch_busy),
		.rd_ack     (rd_ack),
		.bias_out   (bias_out),
		.buf_addr   (buf_addr),
		.buf_data   (buf_data)
	);

endmodule

`default_nettype wire

/* bias_path_assert.sv */
`timescale 1ns/100ps
`default_nettype none

module bias_path_assert (
	input logic clk,
	input logic rst,
	input logic cfg_req,
	input logic cfg_ack,
	input logic fifo_empty,
	input logic fifo_req,
	input logic rd_ack,
	input logic fetch_busy
);

	int fail_count = 0; // Failed assertion count

	////////////////////////////////
	// Handshake rules
	////////////////////////////////

	fifo_req_not_empty: assert property (@(posedge clk) disable iff (rst)
		fifo_empty |-> !fifo_req)
		else begin
			$error("fifo_req high while the FIFO is empty");
			fail_count++;
		end

	// Ack must hold until the request drops
	cfg_ack_held: assert property (@(posedge clk) disable iff (rst)
		(cfg_ack && cfg_req) |=> cfg_ack)
		else begin
			$error("cfg_ack fell while cfg_req was still high");
			fail_count++;
		end

	rd_ack_not_busy: assert property (@(posedge clk) disable iff (rst)
		fetch_busy |-> !rd_ack)
		else begin
			$error("rd_ack high during a fill");
			fail_count++;
		end

endmodule

bind bias_path_top bias_path_assert assert0 (
	.clk        (clk),
	.rst        (rst),
	.cfg_req    (cfg_req),
	.cfg_ack    (cfg_ack),
	.fifo_empty (fifo_empty),
	.fifo_req   (fifo_req),
	.rd_ack     (rd_ack),
	.fetch_busy (fetch_busy)
);

`default_nettype wire

/* bias_path_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "bias_cfg.svh"

module bias_path_tb;

	localparam time DRIVE_DLY = 10;
	localparam int WAIT_LIMIT = 1000; // Cycles per wait

	logic clk, rst;
	logic cfg_req, cfg_ack;
	bias_pkg::word_cnt_t cfg_count;
	bias_pkg::bb_addr_t cfg_addr;
	logic fifo_empty, fifo_req;
	bias_pkg::ddr_word_t fifo_data;
	logic rd_req, rd_ack;
	bias_pkg::bb_addr_t rd_addr;
	bias_pkg::shift_t rd_shift;
	bias_pkg::bias_vec_t bias_out;

	integer seed = 32'h63f1a571;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int fifo_pulses = 0;
	logic stall_en = 1'b0;

	bias_pkg::ddr_word_t fifo_q [$];      // Words the FIFO model still holds
	bias_pkg::ddr_word_t fill_words [$];  // Words for the next fill
	bias_pkg::ddr_word_t model_mem [`BIAS_DEPTH];

	bias_path_top dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	////////////////////////////////
	// DDR FIFO model
	////////////////////////////////

	initial begin : fifo_model
		logic req_seen;
		integer r;
		fifo_empty = 1'b1;
		fifo_data = '0;
		req_seen = 1'b0;
		forever begin
			@(posedge clk);
			#DRIVE_DLY;
			if (req_seen) begin
				fifo_data = fifo_q.pop_front(); // Valid the cycle after the pulse
			end
			r = $random(seed);
			fifo_empty = (fifo_q.size() == 0) || (stall_en && r[0]);
			@(negedge clk);
			req_seen = fifo_req;
			if (fifo_req) fifo_pulses++;
		end
	end

	////////////////////////////////
	// Compare tasks
	////////////////////////////////

	task automatic check_bit(string name, logic got, logic exp);
		checks++;
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %b, expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_word(string name, bias_pkg::ddr_word_t got, bias_pkg::ddr_word_t exp);
		checks++;
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_vec(string name, bias_pkg::bias_vec_t got, bias_pkg::bias_vec_t exp);
		checks++;
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	// Lane value times 2^shift with the low 20 bits kept
	function automatic bias_pkg::bias_vec_t expected_vec(bias_pkg::ddr_word_t w,
			bias_pkg::shift_t sh);
		bias_pkg::bias_vec_t v;
		longint val;
		v = '0;
		for (int k = 0; k < `BIAS_X_PE; k++) begin
			val = longint'($signed(w[k*`BIAS_W +: `BIAS_W]));
			val = val * (longint'(1) << sh);
			v[k*`BIAS_OUT_W +: `BIAS_OUT_W] = val[`BIAS_OUT_W-1:0];
		end
		return v;
	endfunction

	// Low 16 bits of every output lane packed like a stored word
	function automatic bias_pkg::ddr_word_t lanes_low(bias_pkg::bias_vec_t v);
		bias_pkg::ddr_word_t w;
		for (int k = 0; k < `BIAS_X_PE; k++) begin
			w[k*`BIAS_W +: `BIAS_W] = v[k*`BIAS_OUT_W +: `BIAS_W];
		end
		return w;
	endfunction

	////////////////////////////////
	// Drivers and waits
	////////////////////////////////

	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	task automatic wait_cfg_ack(logic level);
		int n;
		n = 0;
		while (cfg_ack !== level && n < WAIT_LIMIT) begin
			next_cycle();
			n++;
		end
		if (cfg_ack !== level) begin
			$display("Timeout at %0t: cfg_ack never went %b", $time, level);
			errors++;
		end
	endtask

	task automatic wait_rd_ack(logic level);
		int n;
		n = 0;
		while (rd_ack !== level && n < WAIT_LIMIT) begin
			next_cycle();
			n++;
		end
		if (rd_ack !== level) begin
			$display("Timeout at %0t: rd_ack never went %b", $time, level);
			errors++;
		end
	endtask

	task automatic add_random_words(int n);
		bias_pkg::ddr_word_t w;
		for (int i = 0; i < n; i++) begin
			w = {$random(seed), $random(seed)};
			fill_words.push_back(w);
		end
	endtask

	// Hands fill_words to the FIFO and raises cfg_req
	task automatic fill_start(bias_pkg::bb_addr_t addr);
		bias_pkg::bb_addr_t a;
		a = addr;
		cfg_count = bias_pkg::word_cnt_t'(fill_words.size());
		foreach (fill_words[i]) begin
			model_mem[a] = fill_words[i];
			fifo_q.push_back(fill_words[i]);
			a = a + 1'b1; // 127 wraps to 0
		end
		fill_words.delete();
		cfg_addr = addr;
		cfg_req = 1'b1;
	endtask

	task automatic fill_finish();
		wait_cfg_ack(1'b1);
		cfg_req = 1'b0;
		wait_cfg_ack(1'b0);
	endtask

	// rd_req is already high
	task automatic read_finish(bias_pkg::bb_addr_t addr, bias_pkg::shift_t sh);
		bias_pkg::bias_vec_t got;
		wait_rd_ack(1'b1);
		got = bias_out;
		check_vec($sformatf("bias_out[%0d]", addr), got, expected_vec(model_mem[addr], sh));
		if (sh == 0) check_word("bias_out lanes", lanes_low(got), model_mem[addr]);
		next_cycle();
		check_vec("bias_out hold", bias_out, got); // Still acked so it must not move
		rd_req = 1'b0;
		wait_rd_ack(1'b0);
	endtask

	task automatic read_check(bias_pkg::bb_addr_t addr, bias_pkg::shift_t sh);
		rd_addr = addr;
		rd_shift = sh;
		rd_req = 1'b1;
		read_finish(addr, sh);
	endtask

	task automatic end_test(string name, int err_before);
		tests++;
		if (errors == err_before) $display("Test %s passed", name);
		else $display("Test %s failed with %0d errors", name, errors - err_before);
	endtask

	////////////////////////////////
	// Tests
	////////////////////////////////

	task automatic test_reset_values();
		int e;
		e = errors;
		check_bit("cfg_ack", cfg_ack, 1'b0);
		check_bit("rd_ack", rd_ack, 1'b0);
		check_bit("fifo_req", fifo_req, 1'b0);
		end_test("reset_values", e);
	endtask

	task automatic test_fill_read();
		int e;
		e = errors;
		add_random_words(8);
		fill_start(10);
		fill_finish();
		for (int i = 0; i < 8; i++) read_check(10 + i, 0);
		end_test("fill_read", e);
	endtask

	task automatic test_shift();
		int e;
		e = errors;
		fill_words.push_back({16'h8000, 16'hffff, 16'h7fff, 16'h1234});
		fill_words.push_back({16'hc000, 16'h0001, 16'hff80, 16'h4000});
		fill_start(70);
		fill_finish();
		for (int i = 0; i < 2; i++) begin
			read_check(70 + i, 1);
			read_check(70 + i, 4);
			read_check(70 + i, 9);
		end
		end_test("shift", e);
	endtask

	task automatic test_stalls();
		int e;
		e = errors;
		stall_en = 1'b1;
		add_random_words(20);
		fill_start(30);
		fill_finish();
		stall_en = 1'b0;
		for (int i = 0; i < 20; i++) read_check(30 + i, 0);
		end_test("fifo_stalls", e);
	endtask

	task automatic test_wrap_zero();
		int e;
		int pulses;
		e = errors;
		add_random_words(4);
		fill_start(126);
		fill_finish();
		read_check(126, 0);
		read_check(127, 0);
		read_check(0, 0);
		read_check(1, 0);
		pulses = fifo_pulses;
		fifo_q.push_back({$random(seed), $random(seed)}); // FIFO holds a word it must not give
		fill_start(5);
		fill_finish();
		checks++;
		if (fifo_pulses != pulses) begin
			$display("fifo_req pulsed during a zero count fill at %0t", $time);
			errors++;
		end
		fifo_q.delete();
		end_test("wrap_zero", e);
	endtask

	task automatic test_read_in_fill();
		int e;
		int n;
		e = errors;
		add_random_words(6);
		fill_start(90);
		fill_finish();
		add_random_words(6); // Rewrites 90..95
		fill_start(90);
		next_cycle();
		next_cycle();
		rd_addr = 93;
		rd_shift = 0;
		rd_req = 1'b1;
		n = 0;
		while (cfg_ack !== 1'b1 && n < WAIT_LIMIT) begin
			next_cycle();
			n++;
			if (rd_ack === 1'b1 && cfg_ack !== 1'b1) begin
				$display("rd_ack rose before the fill completed at %0t", $time);
				errors++;
			end
		end
		if (cfg_ack !== 1'b1) begin
			$display("Timeout at %0t: fill never acknowledged", $time);
			errors++;
		end
		cfg_req = 1'b0;
		wait_cfg_ack(1'b0);
		read_finish(93, 0);
		end_test("read_in_fill", e);
	endtask

	initial begin
		rst = 1'b1;
		cfg_req = 1'b0;
		cfg_count = '0;
		cfg_addr = '0;
		rd_req = 1'b0;
		rd_addr = '0;
		rd_shift = '0;
		repeat (3) @(posedge clk);
		#DRIVE_DLY;
		rst = 1'b0;

		test_reset_values();
		test_fill_read();
		test_shift();
		test_stalls();
		test_wrap_zero();
		test_read_in_fill();

		if (dut0.assert0.fail_count != 0) begin
			$display("Concurrent assertions failed %0d times", dut0.assert0.fail_count);
			errors += dut0.assert0.fail_count;
		end

		$display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+.
bias_pkg.sv
bias_fetch.sv
bias_buffer.sv
bias_reader.sv
bias_path_top.sv
bias_path_assert.sv
bias_path_tb.sv

/* Bender.yml */
package:
  name: bias_path

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - bias_pkg.sv
      - bias_fetch.sv
      - bias_buffer.sv
      - bias_reader.sv
      - bias_path_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - bias_path_assert.sv
      - bias_path_tb.sv
